// ==== mem_req_path.f ====
common/mem_cfg_pkg.sv
common/mem_req_pkg.sv
source/mem_fifo_buf.sv
source/mem_req_arbiter.sv
source/mem_req_path.sv
test/mem_req_checker.sv
test/mem_req_path_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module mem_req_path_tb \
    -f mem_req_path.f \
    --Mdir obj_dir -o sim_mem_req_path

output=$(./obj_dir/sim_mem_req_path 2>&1) || true
echo "$output"

if grep -q "All tests passed!" <<< "$output"; then
    exit 0
fi
echo "Simulation did not pass"
exit 1

// ==== test/mem_req_path_tb.sv ====
`timescale 1ns/1ps

module mem_req_path_tb;

    import mem_cfg_pkg::*;

    localparam int NUM_REQ        = 200;
    localparam int TIMEOUT_CYCLES = 8 * 2 * NUM_REQ + 200;

    logic                      clk;
    logic                      reset;
    logic                      rd_req_valid;
    logic [ADDR_W-1:0]         rd_req_addr;
    logic [TAG_W-1:0]          rd_req_tag;
    logic [LEN_W-1:0]          rd_req_len;
    logic                      rd_req_ready;
    logic                      wr_req_valid;
    logic [ADDR_W-1:0]         wr_req_addr;
    logic [DATA_W-1:0]         wr_req_data;
    logic                      wr_req_ready;
    logic [QUEUE_DEPTH_LOG2:0] rd_space;
    logic [QUEUE_DEPTH_LOG2:0] wr_space;
    logic                      mem_valid;
    logic                      mem_write;
    logic [ADDR_W-1:0]         mem_addr;
    logic [DATA_W-1:0]         mem_wdata;
    logic [TAG_W-1:0]          mem_tag;
    logic [LEN_W-1:0]          mem_len;
    logic                      mem_ready;
    logic                      end_check;
    logic                      end_done;
    int                        error_count;
    int                        reads_seen;
    int                        writes_seen;
    int                        cycle_count;
    integer                    seed;
    integer                    ready_seed;

    logic [ADDR_W-1:0] rd_addr_list [NUM_REQ];
    logic [TAG_W-1:0]  rd_tag_list  [NUM_REQ];
    logic [LEN_W-1:0]  rd_len_list  [NUM_REQ];
    int                rd_gap_list  [NUM_REQ];
    logic [ADDR_W-1:0] wr_addr_list [NUM_REQ];
    logic [DATA_W-1:0] wr_data_list [NUM_REQ];
    int                wr_gap_list  [NUM_REQ];

    mem_req_path u_dut (
        .clk          (clk),
        .reset        (reset),
        .rd_req_valid (rd_req_valid),
        .rd_req_addr  (rd_req_addr),
        .rd_req_tag   (rd_req_tag),
        .rd_req_len   (rd_req_len),
        .rd_req_ready (rd_req_ready),
        .wr_req_valid (wr_req_valid),
        .wr_req_addr  (wr_req_addr),
        .wr_req_data  (wr_req_data),
        .wr_req_ready (wr_req_ready),
        .rd_space     (rd_space),
        .wr_space     (wr_space),
        .mem_valid    (mem_valid),
        .mem_write    (mem_write),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_tag      (mem_tag),
        .mem_len      (mem_len),
        .mem_ready    (mem_ready)
    );

    mem_req_checker #(
        .NUM_REQ (NUM_REQ)
    ) u_chk (
        .clk          (clk),
        .reset        (reset),
        .rd_req_valid (rd_req_valid),
        .rd_req_addr  (rd_req_addr),
        .rd_req_tag   (rd_req_tag),
        .rd_req_len   (rd_req_len),
        .rd_req_ready (rd_req_ready),
        .wr_req_valid (wr_req_valid),
        .wr_req_addr  (wr_req_addr),
        .wr_req_data  (wr_req_data),
        .wr_req_ready (wr_req_ready),
        .rd_space     (rd_space),
        .wr_space     (wr_space),
        .mem_valid    (mem_valid),
        .mem_write    (mem_write),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_tag      (mem_tag),
        .mem_len      (mem_len),
        .mem_ready    (mem_ready),
        .end_check    (end_check),
        .error_count  (error_count),
        .reads_seen   (reads_seen),
        .writes_seen  (writes_seen),
        .end_done     (end_done)
    );

    always #50 clk = ~clk;

    // All request fields come from one seed before the run starts
    task automatic make_requests();
        logic [31:0] r;
        for (int i = 0; i < NUM_REQ; i++) begin
            rd_addr_list[i] = $random(seed);
            r = $random(seed);
            rd_tag_list[i] = r[TAG_W-1:0];
            rd_len_list[i] = r[TAG_W +: LEN_W];
            rd_gap_list[i] = int'(r[17:16]);  // Up to 3 idle cycles before the request
            wr_addr_list[i] = $random(seed);
            wr_data_list[i] = $random(seed);
            r = $random(seed);
            wr_gap_list[i] = int'(r[1:0]);
        end
    endtask

    task automatic send_reads();
        logic accepted;
        for (int i = 0; i < NUM_REQ; i++) begin
            rd_req_valid = 1'b0;
            repeat (rd_gap_list[i]) @(negedge clk);
            rd_req_valid = 1'b1;
            rd_req_addr  = rd_addr_list[i];
            rd_req_tag   = rd_tag_list[i];
            rd_req_len   = rd_len_list[i];
            accepted     = 1'b0;
            while (!accepted) begin
                accepted = rd_req_ready;  // Registered, so it holds until the rising edge
                @(negedge clk);
            end
        end
        rd_req_valid = 1'b0;
    endtask

    task automatic send_writes();
        logic accepted;
        for (int i = 0; i < NUM_REQ; i++) begin
            wr_req_valid = 1'b0;
            repeat (wr_gap_list[i]) @(negedge clk);
            wr_req_valid = 1'b1;
            wr_req_addr  = wr_addr_list[i];
            wr_req_data  = wr_data_list[i];
            accepted     = 1'b0;
            while (!accepted) begin
                accepted = wr_req_ready;
                @(negedge clk);
            end
        end
        wr_req_valid = 1'b0;
    endtask

    // Memory side alternates between busy phases and long stalls
    initial begin
        int  phase_len;
        logic stall;
        @(negedge reset);
        forever begin
            phase_len = 8 + ($unsigned($random(ready_seed)) % 40);
            stall     = ($unsigned($random(ready_seed)) % 4) == 0;
            repeat (phase_len) begin
                @(negedge clk);
                if (stall) begin
                    mem_ready = ($unsigned($random(ready_seed)) % 10) == 0;
                end else begin
                    mem_ready = ($unsigned($random(ready_seed)) % 4) != 0;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        rd_req_valid = 1'b0;
        rd_req_addr  = '0;
        rd_req_tag   = '0;
        rd_req_len   = '0;
        wr_req_valid = 1'b0;
        wr_req_addr  = '0;
        wr_req_data  = '0;
        mem_ready    = 1'b0;
        end_check    = 1'b0;
        cycle_count  = 0;
        seed         = 2272;
        ready_seed   = seed + 1;
        make_requests();
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        fork
            send_reads();
            send_writes();
        join
        while (reads_seen < NUM_REQ || writes_seen < NUM_REQ) @(negedge clk);
        repeat (4) @(negedge clk);
        end_check = 1'b1;
        while (!end_done) @(negedge clk);
        $display("Run finished with %0d errors, %0d reads and %0d writes seen",
                 error_count, reads_seen, writes_seen);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== test/mem_req_checker.sv ====
`timescale 1ns/1ps

module mem_req_checker #(
    parameter int NUM_REQ = 200
) (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   rd_req_valid,
    input  logic [mem_cfg_pkg::ADDR_W-1:0]         rd_req_addr,
    input  logic [mem_cfg_pkg::TAG_W-1:0]          rd_req_tag,
    input  logic [mem_cfg_pkg::LEN_W-1:0]          rd_req_len,
    input  logic                                   rd_req_ready,
    input  logic                                   wr_req_valid,
    input  logic [mem_cfg_pkg::ADDR_W-1:0]         wr_req_addr,
    input  logic [mem_cfg_pkg::DATA_W-1:0]         wr_req_data,
    input  logic                                   wr_req_ready,
    input  logic [mem_cfg_pkg::QUEUE_DEPTH_LOG2:0] rd_space,
    input  logic [mem_cfg_pkg::QUEUE_DEPTH_LOG2:0] wr_space,
    input  logic                                   mem_valid,
    input  logic                                   mem_write,
    input  logic [mem_cfg_pkg::ADDR_W-1:0]         mem_addr,
    input  logic [mem_cfg_pkg::DATA_W-1:0]         mem_wdata,
    input  logic [mem_cfg_pkg::TAG_W-1:0]          mem_tag,
    input  logic [mem_cfg_pkg::LEN_W-1:0]          mem_len,
    input  logic                                   mem_ready,
    input  logic                                   end_check,
    output int                                     error_count,
    output int                                     reads_seen,
    output int                                     writes_seen,
    output logic                                   end_done
);

    import mem_cfg_pkg::*;

    // Write flag, address, write data, tag and length in port order
    typedef logic [ADDR_W+DATA_W+TAG_W+LEN_W:0] cmd_t;

    logic [ADDR_W-1:0] rd_addr_q [$];
    logic [TAG_W-1:0]  rd_tag_q  [$];
    logic [LEN_W-1:0]  rd_len_q  [$];
    logic [ADDR_W-1:0] wr_addr_q [$];
    logic [DATA_W-1:0] wr_data_q [$];
    cmd_t              exp_cmd;
    cmd_t              cur_cmd;
    cmd_t              prev_cmd;
    logic              exp_valid;
    logic              stall_prev;
    logic              after_reset;
    int                rd_pending;
    int                wr_pending;

    // Reads go first unless the write queue is close to full
    function automatic logic choose_write(input int rd_cnt, input int wr_cnt);
        if (wr_cnt == 0) begin
            return 1'b0;
        end else if (rd_cnt == 0) begin
            return 1'b1;
        end
        return (QUEUE_ENTRIES - wr_cnt) <= WR_URGENT_SPACE;
    endfunction

    function automatic cmd_t predict_cmd(input logic is_wr, input logic [ADDR_W-1:0] addr,
                                         input logic [DATA_W-1:0] data,
                                         input logic [TAG_W-1:0] tag,
                                         input logic [LEN_W-1:0] len);
        if (is_wr) begin
            return {1'b1, addr, data, {TAG_W{1'b0}}, {LEN_W{1'b0}}};
        end else begin
            return {1'b0, addr, {DATA_W{1'b0}}, tag, len};
        end
    endfunction

    task automatic flag_error(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        error_count++;
    endtask

    task automatic check_space(input string name, input int space, input int pending,
                               input logic ready);
        if (space != QUEUE_ENTRIES - pending) begin
            flag_error($sformatf("%s space is %0d, expected %0d", name, space,
                                 QUEUE_ENTRIES - pending));
        end
        if (ready !== (space != 0)) begin
            flag_error($sformatf("%s ready is %b with space %0d", name, ready, space));
        end
    endtask

    always @(posedge clk) begin
        cur_cmd = {mem_write, mem_addr, mem_wdata, mem_tag, mem_len};
        if (reset) begin
            rd_addr_q.delete();
            rd_tag_q.delete();
            rd_len_q.delete();
            wr_addr_q.delete();
            wr_data_q.delete();
            exp_valid   = 1'b0;
            stall_prev  = 1'b0;
            after_reset = 1'b1;
            error_count = 0;
            reads_seen  = 0;
            writes_seen = 0;
            end_done    = 1'b0;
        end else begin
            if (after_reset && (mem_valid !== 1'b0 || !rd_req_ready || !wr_req_ready)) begin
                flag_error("ports not idle after reset");
            end
            after_reset = 1'b0;
            check_space("read", int'(rd_space), rd_addr_q.size(), rd_req_ready);
            check_space("write", int'(wr_space), wr_addr_q.size(), wr_req_ready);

            if (mem_valid !== exp_valid) begin
                flag_error($sformatf("mem_valid is %b, expected %b", mem_valid, exp_valid));
            end else if (exp_valid && cur_cmd !== exp_cmd) begin
                flag_error($sformatf("command %h, expected %h", cur_cmd, exp_cmd));
            end
            if (stall_prev && cur_cmd !== prev_cmd) begin
                flag_error("memory command changed during a stall");
            end
            if (mem_valid && mem_ready) begin
                if (mem_write) begin
                    writes_seen++;
                end else begin
                    reads_seen++;
                end
            end
            stall_prev = mem_valid && !mem_ready;
            prev_cmd   = cur_cmd;

            // The register takes the chosen head entry on this edge
            if (!mem_valid || mem_ready) begin
                rd_pending = rd_addr_q.size();
                wr_pending = wr_addr_q.size();
                exp_valid  = (rd_pending + wr_pending) > 0;
                if (exp_valid && choose_write(rd_pending, wr_pending)) begin
                    exp_cmd = predict_cmd(1'b1, wr_addr_q.pop_front(), wr_data_q.pop_front(),
                                          '0, '0);
                end else if (exp_valid) begin
                    exp_cmd = predict_cmd(1'b0, rd_addr_q.pop_front(), '0,
                                          rd_tag_q.pop_front(), rd_len_q.pop_front());
                end
            end

            if (rd_req_valid && rd_req_ready) begin
                rd_addr_q.push_back(rd_req_addr);
                rd_tag_q.push_back(rd_req_tag);
                rd_len_q.push_back(rd_req_len);
            end
            if (wr_req_valid && wr_req_ready) begin
                wr_addr_q.push_back(wr_req_addr);
                wr_data_q.push_back(wr_req_data);
            end

            if (end_check && !end_done) begin
                if (reads_seen != NUM_REQ || writes_seen != NUM_REQ) begin
                    flag_error($sformatf("saw %0d reads and %0d writes, expected %0d each",
                                         reads_seen, writes_seen, NUM_REQ));
                end
                if (rd_addr_q.size() != 0 || wr_addr_q.size() != 0 || exp_valid) begin
                    flag_error("requests still pending at the end");
                end
                if (int'(rd_space) != QUEUE_ENTRIES || int'(wr_space) != QUEUE_ENTRIES) begin
                    flag_error("queues not empty at the end");
                end
                end_done = 1'b1;
            end
        end
    end

endmodule

// ==== source/mem_req_path.sv ====
`timescale 1ns/1ps

module mem_req_path (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   rd_req_valid,
    input  logic [mem_cfg_pkg::ADDR_W-1:0]         rd_req_addr,
    input  logic [mem_cfg_pkg::TAG_W-1:0]          rd_req_tag,
    input  logic [mem_cfg_pkg::LEN_W-1:0]          rd_req_len,
    output logic                                   rd_req_ready,
    input  logic                                   wr_req_valid,
    input  logic [mem_cfg_pkg::ADDR_W-1:0]         wr_req_addr,
    input  logic [mem_cfg_pkg::DATA_W-1:0]         wr_req_data,
    output logic                                   wr_req_ready,
    output logic [mem_cfg_pkg::QUEUE_DEPTH_LOG2:0] rd_space,
    output logic [mem_cfg_pkg::QUEUE_DEPTH_LOG2:0] wr_space,
    output logic                                   mem_valid,
    output logic                                   mem_write,
    output logic [mem_cfg_pkg::ADDR_W-1:0]         mem_addr,
    output logic [mem_cfg_pkg::DATA_W-1:0]         mem_wdata,
    output logic [mem_cfg_pkg::TAG_W-1:0]          mem_tag,
    output logic [mem_cfg_pkg::LEN_W-1:0]          mem_len,
    input  logic                                   mem_ready
);

    import mem_cfg_pkg::*;
    import mem_req_pkg::*;

    mem_entry_u        rd_entry;
    mem_entry_u        wr_entry;
    logic              rd_full, rd_empty, rd_pop;
    logic              wr_full, wr_empty, wr_pop;
    logic [WORD_W-1:0] rd_head;
    logic [WORD_W-1:0] wr_head;

    assign rd_entry.rd = '{addr: rd_req_addr, tag: rd_req_tag, len: rd_req_len, rsvd: '0};
    assign wr_entry.wr = '{addr: wr_req_addr, data: wr_req_data};

    // The queue drops a write while full, which is exactly when ready is low
    assign rd_req_ready = ~rd_full;
    assign wr_req_ready = ~wr_full;

    mem_fifo_buf #(
        .WIDTH (WORD_W),
        .DEPTH (QUEUE_DEPTH_LOG2)
    ) u_rd_queue (
        .clk    (clk),
        .reset  (reset),
        .rd     (rd_pop),
        .wr     (rd_req_valid),
        .w_data (rd_entry),
        .empty  (rd_empty),
        .full   (rd_full),
        .r_data (rd_head),
        .space  (rd_space)
    );

    mem_fifo_buf #(
        .WIDTH (WORD_W),
        .DEPTH (QUEUE_DEPTH_LOG2)
    ) u_wr_queue (
        .clk    (clk),
        .reset  (reset),
        .rd     (wr_pop),
        .wr     (wr_req_valid),
        .w_data (wr_entry),
        .empty  (wr_empty),
        .full   (wr_full),
        .r_data (wr_head),
        .space  (wr_space)
    );

    mem_req_arbiter u_arb (
        .clk        (clk),
        .reset      (reset),
        .rd_q_data  (rd_head),
        .rd_q_empty (rd_empty),
        .rd_q_space (rd_space),
        .wr_q_data  (wr_head),
        .wr_q_empty (wr_empty),
        .wr_q_space (wr_space),
        .mem_ready  (mem_ready),
        .rd_q_pop   (rd_pop),
        .wr_q_pop   (wr_pop),
        .mem_valid  (mem_valid),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_tag    (mem_tag),
        .mem_len    (mem_len)
    );

endmodule

// ==== source/mem_req_arbiter.sv ====
`timescale 1ns/1ps

module mem_req_arbiter (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic [mem_cfg_pkg::WORD_W-1:0]       rd_q_data,
    input  logic                                 rd_q_empty,
    input  logic [mem_cfg_pkg::QUEUE_DEPTH_LOG2:0] rd_q_space,
    input  logic [mem_cfg_pkg::WORD_W-1:0]       wr_q_data,
    input  logic                                 wr_q_empty,
    input  logic [mem_cfg_pkg::QUEUE_DEPTH_LOG2:0] wr_q_space,
    input  logic                                 mem_ready,
    output logic                                 rd_q_pop,
    output logic                                 wr_q_pop,
    output logic                                 mem_valid,
    output logic                                 mem_write,
    output logic [mem_cfg_pkg::ADDR_W-1:0]       mem_addr,
    output logic [mem_cfg_pkg::DATA_W-1:0]       mem_wdata,
    output logic [mem_cfg_pkg::TAG_W-1:0]        mem_tag,
    output logic [mem_cfg_pkg::LEN_W-1:0]        mem_len
);

    import mem_cfg_pkg::*;
    import mem_req_pkg::*;

    logic              out_free;
    logic              wr_urgent;
    logic              pick_wr;
    logic              pick_rd;
    logic              load;
    mem_entry_u        sel_entry;
    logic [ADDR_W-1:0] cmd_addr;
    logic [DATA_W-1:0] cmd_wdata;
    logic [TAG_W-1:0]  cmd_tag;
    logic [LEN_W-1:0]  cmd_len;

    // The command register can take a new entry when it is empty or drains this cycle
    assign out_free = ~mem_valid | mem_ready;

    assign wr_urgent = (wr_q_space <= WR_URGENT_SPACE);

    // Reads win a tie unless the write queue is about to fill up
    assign pick_wr = ~wr_q_empty & (rd_q_empty | wr_urgent);
    assign pick_rd = ~rd_q_empty & ~pick_wr;

    assign rd_q_pop = out_free & pick_rd;
    assign wr_q_pop = out_free & pick_wr;
    assign load     = rd_q_pop | wr_q_pop;

    assign sel_entry = pick_wr ? wr_q_data : rd_q_data;

    always_comb begin
        cmd_addr = sel_entry.rd.addr;  // Both views keep the address in the top bits
        if (pick_wr) begin
            cmd_wdata = sel_entry.wr.data;
            cmd_tag   = '0;
            cmd_len   = '0;
        end else begin
            cmd_wdata = '0;  // The controller expects no data on reads
            cmd_tag   = sel_entry.rd.tag;
            cmd_len   = sel_entry.rd.len;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mem_valid <= 1'b0;
        end else if (out_free) begin
            mem_valid <= load;
        end
    end

    // Fields only change on a pop, so they hold through a stall
    always_ff @(posedge clk) begin
        if (load) begin
            mem_write <= pick_wr;
            mem_addr  <= cmd_addr;
            mem_wdata <= cmd_wdata;
            mem_tag   <= cmd_tag;
            mem_len   <= cmd_len;
        end
    end

    a_one_pop: assert property (@(posedge clk) disable iff (reset)
        !(rd_q_pop && wr_q_pop))
        else $error("Both queues popped in one cycle");

    // The queue's own space count must agree that an entry is there
    a_rd_pop_nonempty: assert property (@(posedge clk) disable iff (reset)
        rd_q_pop |-> !rd_q_empty && (rd_q_space < QUEUE_ENTRIES))
        else $error("Read queue popped while empty");

    a_wr_pop_nonempty: assert property (@(posedge clk) disable iff (reset)
        wr_q_pop |-> !wr_q_empty && (wr_q_space < QUEUE_ENTRIES))
        else $error("Write queue popped while empty");

    a_stall_hold: assert property (@(posedge clk) disable iff (reset)
        mem_valid && !mem_ready |=>
            mem_valid && $stable({mem_write, mem_addr, mem_wdata, mem_tag, mem_len}))
        else $error("Memory command changed during a stall");

endmodule

// ==== source/mem_fifo_buf.sv ====
`timescale 1ns/1ps

module mem_fifo_buf #(
    parameter int WIDTH = mem_cfg_pkg::WORD_W,
    parameter int DEPTH = mem_cfg_pkg::QUEUE_DEPTH_LOG2
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             rd,
    input  logic             wr,
    input  logic [WIDTH-1:0] w_data,
    output logic             empty,
    output logic             full,
    output logic [WIDTH-1:0] r_data,
    output logic [DEPTH:0]   space
);

    logic [WIDTH-1:0] array_reg [2**DEPTH];
    logic [DEPTH-1:0] w_ptr_reg, w_ptr_next;
    logic [DEPTH-1:0] r_ptr_reg, r_ptr_next;
    logic             full_reg, full_next;
    logic             empty_reg, empty_next;
    logic [DEPTH:0]   space_next;
    logic             wr_en;
    logic             rd_en;

    // A write on a full queue and a read on an empty one are dropped.
    // This also settles the simultaneous case at both ends
    assign wr_en = wr & ~full_reg;
    assign rd_en = rd & ~empty_reg;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            array_reg[w_ptr_reg] <= w_data;
        end
    end

    assign r_data = array_reg[r_ptr_reg];  // Head of queue, valid while not empty

    always_comb begin
        w_ptr_next = wr_en ? w_ptr_reg + 1'b1 : w_ptr_reg;
        r_ptr_next = rd_en ? r_ptr_reg + 1'b1 : r_ptr_reg;
        full_next  = full_reg;
        empty_next = empty_reg;

        case ({wr_en, rd_en})
            2'b10: begin
                empty_next = 1'b0;
                full_next  = (w_ptr_next == r_ptr_reg);
            end
            2'b01: begin
                full_next  = 1'b0;
                empty_next = (r_ptr_next == w_ptr_reg);
            end
            default: ;  // Idle, or both pointers move and the fill level holds
        endcase
    end

    // Equal pointers are ambiguous, so the flags decide those two cases
    always_comb begin
        if (full_next) begin
            space_next = '0;
        end else if (empty_next) begin
            space_next = {1'b1, {DEPTH{1'b0}}};
        end else begin
            space_next = {1'b0, r_ptr_next - w_ptr_next};
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            w_ptr_reg <= '0;
            r_ptr_reg <= '0;
            full_reg  <= 1'b0;
            empty_reg <= 1'b1;
            space     <= {1'b1, {DEPTH{1'b0}}};
        end else begin
            w_ptr_reg <= w_ptr_next;
            r_ptr_reg <= r_ptr_next;
            full_reg  <= full_next;
            empty_reg <= empty_next;
            space     <= space_next;
        end
    end

    assign full  = full_reg;
    assign empty = empty_reg;

    a_not_full_and_empty: assert property (@(posedge clk) disable iff (reset)
        !(full && empty))
        else $error("FIFO flags full and empty together");

    a_space_full: assert property (@(posedge clk) disable iff (reset)
        (space == '0) == full)
        else $error("FIFO space count disagrees with full flag");

    a_space_empty: assert property (@(posedge clk) disable iff (reset)
        (space == {1'b1, {DEPTH{1'b0}}}) == empty)
        else $error("FIFO space count disagrees with empty flag");

endmodule

// ==== common/mem_req_pkg.sv ====
package mem_req_pkg;

    // Bits left over in a read entry once address, tag and length are placed
    localparam int RD_RSVD_W = mem_cfg_pkg::WORD_W - mem_cfg_pkg::ADDR_W
                             - mem_cfg_pkg::TAG_W - mem_cfg_pkg::LEN_W;

    // Read request view of a queue word
    typedef struct packed {
        logic [mem_cfg_pkg::ADDR_W-1:0] addr;
        logic [mem_cfg_pkg::TAG_W-1:0]  tag;
        logic [mem_cfg_pkg::LEN_W-1:0]  len;
        logic [RD_RSVD_W-1:0]           rsvd;  // Written as zero, never read back
    } rd_entry_t;

    // Write request view of a queue word
    typedef struct packed {
        logic [mem_cfg_pkg::ADDR_W-1:0] addr;
        logic [mem_cfg_pkg::DATA_W-1:0] data;
    } wr_entry_t;

    // The address sits in the top bits in both views
    typedef union packed {
        rd_entry_t rd;
        wr_entry_t wr;
    } mem_entry_u;

endpackage

// ==== common/mem_cfg_pkg.sv ====
package mem_cfg_pkg;

    // Request field widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int TAG_W  = 8;   // Read tag returned with the data by the controller
    localparam int LEN_W  = 8;   // Read burst length in beats

    // One queue entry carries either request type
    localparam int WORD_W = 64;

    // Each request queue holds 2**QUEUE_DEPTH_LOG2 entries
    localparam int QUEUE_DEPTH_LOG2 = 3;
    localparam int QUEUE_ENTRIES    = 1 << QUEUE_DEPTH_LOG2;

    // Writes jump ahead of reads once the write queue is this close to full
    localparam int WR_URGENT_SPACE = 2;

endpackage
